/* hdl/cond_eval.sv */
/*
  condition check
  turns a 4 bit condition code and the current flags into a go / no-go
*/
`timescale 1ns/1ps

module cond_eval (
  input  exec_pkg::cond_t  cond,
  input  exec_pkg::flags_t flags,
  output logic             cond_true
);

  logic c, s, v, z, ge;

  assign c  = flags[exec_pkg::FL_C];
  assign s  = flags[exec_pkg::FL_S];
  assign v  = flags[exec_pkg::FL_V];
  assign z  = flags[exec_pkg::FL_Z];
  assign ge = s == v;

  always_comb begin
    cond_true = 1'b0;
    case (cond)
      exec_pkg::CC_Z:     cond_true = z;
      exec_pkg::CC_NZ:    cond_true = !z;
      exec_pkg::CC_C:     cond_true = c;
      exec_pkg::CC_NC:    cond_true = !c;
      exec_pkg::CC_S:     cond_true = s;
      exec_pkg::CC_NS:    cond_true = !s;
      exec_pkg::CC_V:     cond_true = v;
      exec_pkg::CC_NV:    cond_true = !v;
      exec_pkg::CC_A:     cond_true = c && !z;
      exec_pkg::CC_BE:    cond_true = !(c && !z);
      exec_pkg::CC_LT:    cond_true = !ge;
      exec_pkg::CC_GE:    cond_true = ge;
      exec_pkg::CC_GT:    cond_true = !z && ge;
      exec_pkg::CC_LE:    cond_true = z || !ge;
      exec_pkg::CC_AL:    cond_true = 1'b1;
      exec_pkg::CC_NEVER: cond_true = 1'b0;
      default:            cond_true = 1'b0;
    endcase
  end

endmodule

/* hdl/exec_core.sv */
/*
  integer execution slice
  Wishbone host port, instruction decoder, condition check, ALU and
  register file of one execution slice
*/
`timescale 1ns/1ps

module exec_core (
  input  logic               clk,
  input  logic               rst,
  input  logic               wb_cyc,
  input  logic               wb_stb,
  input  logic               wb_we,
  input  exec_pkg::bus_adr_t wb_adr,
  input  exec_pkg::data_t    wb_dat_w,
  output exec_pkg::data_t    wb_dat_r,
  output logic               wb_ack
);

  logic               issue;
  exec_pkg::insn_t    issue_insn;
  logic               host_we;
  exec_pkg::reg_idx_t host_widx;
  exec_pkg::data_t    host_wdata;
  logic               host_flags_we;
  exec_pkg::flags_t   host_flags;
  exec_pkg::reg_idx_t host_ridx;
  exec_pkg::data_t    host_rdata;
  exec_pkg::flags_t   flags;

  logic               op_valid;
  exec_pkg::alu_op_t  op;
  exec_pkg::cond_t    cond;
  exec_pkg::reg_idx_t rd, ra, rb;
  exec_pkg::data_t    imm;
  exec_pkg::data_t    ra_data, rb_data;
  logic               cond_true;
  logic               alu_we;
  exec_pkg::reg_idx_t alu_rd;
  exec_pkg::data_t    alu_wdata;
  logic               flags_we;
  exec_pkg::flags_t   new_flags;

  host_port u_host_port (
    .clk(clk), .rst(rst),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .issue(issue), .issue_insn(issue_insn),
    .host_we(host_we), .host_widx(host_widx), .host_wdata(host_wdata),
    .host_flags_we(host_flags_we), .host_flags(host_flags),
    .host_ridx(host_ridx), .host_rdata(host_rdata), .flags(flags)
  );

  insn_decode u_insn_decode (
    .clk(clk), .rst(rst), .issue(issue), .issue_insn(issue_insn),
    .op_valid(op_valid), .op(op), .cond(cond),
    .rd(rd), .ra(ra), .rb(rb), .imm(imm)
  );

  cond_eval u_cond_eval (
    .cond(cond), .flags(flags), .cond_true(cond_true)
  );

  int_alu u_int_alu (
    .op_valid(op_valid), .op(op), .rd(rd), .imm(imm),
    .ra_data(ra_data), .rb_data(rb_data), .flags(flags), .cond_true(cond_true),
    .alu_we(alu_we), .alu_rd(alu_rd), .alu_wdata(alu_wdata),
    .flags_we(flags_we), .new_flags(new_flags)
  );

  reg_file u_reg_file (
    .clk(clk), .rst(rst),
    .ra(ra), .rb(rb), .ra_data(ra_data), .rb_data(rb_data),
    .host_ridx(host_ridx), .host_rdata(host_rdata),
    .alu_we(alu_we), .rd(alu_rd), .alu_wdata(alu_wdata),
    .flags_we(flags_we), .new_flags(new_flags),
    .host_we(host_we), .host_widx(host_widx), .host_wdata(host_wdata),
    .host_flags_we(host_flags_we), .host_flags(host_flags), .flags(flags)
  );

endmodule

/* hdl/exec_pkg.sv */
/*
  exec package
  shared widths, opcode and condition encodings, instruction field
  positions and the host bus address map of the integer slice
*/
package exec_pkg;

  typedef logic [63:0] data_t;
  typedef logic [5:0]  reg_idx_t;
  typedef logic [3:0]  flags_t;   // c, s, v, z from msb down
  typedef logic [3:0]  cond_t;
  typedef logic [3:0]  alu_op_t;
  typedef logic [31:0] insn_t;
  typedef logic [7:0]  bus_adr_t;

  // flag bit positions
  localparam int FL_C = 3;
  localparam int FL_S = 2;
  localparam int FL_V = 1;
  localparam int FL_Z = 0;

  // opcodes, 10..15 reserved
  localparam alu_op_t OP_ADD  = 4'd0;
  localparam alu_op_t OP_SUB  = 4'd1;
  localparam alu_op_t OP_AND  = 4'd2;
  localparam alu_op_t OP_XOR  = 4'd3;
  localparam alu_op_t OP_OR   = 4'd4;
  localparam alu_op_t OP_SHL  = 4'd5;
  localparam alu_op_t OP_SHR  = 4'd6;
  localparam alu_op_t OP_SAR  = 4'd7;
  localparam alu_op_t OP_ADDI = 4'd8;
  localparam alu_op_t OP_MOVI = 4'd9;

  localparam cond_t CC_Z     = 4'd0;
  localparam cond_t CC_NZ    = 4'd1;
  localparam cond_t CC_C     = 4'd2;
  localparam cond_t CC_NC    = 4'd3;
  localparam cond_t CC_S     = 4'd4;
  localparam cond_t CC_NS    = 4'd5;
  localparam cond_t CC_V     = 4'd6;
  localparam cond_t CC_NV    = 4'd7;
  localparam cond_t CC_A     = 4'd8;   // unsigned above
  localparam cond_t CC_BE    = 4'd9;
  localparam cond_t CC_LT    = 4'd10;  // signed
  localparam cond_t CC_GE    = 4'd11;
  localparam cond_t CC_GT    = 4'd12;
  localparam cond_t CC_LE    = 4'd13;
  localparam cond_t CC_AL    = 4'd14;
  localparam cond_t CC_NEVER = 4'd15;

  // instruction field lsb positions
  localparam int INSN_OP_LSB   = 28;
  localparam int INSN_COND_LSB = 24;
  localparam int INSN_RD_LSB   = 18;
  localparam int INSN_RA_LSB   = 12;
  localparam int INSN_RB_LSB   = 6;
  localparam int INSN_IMM_W    = 12;

  localparam bus_adr_t ADR_ISSUE    = 8'h00;
  localparam bus_adr_t ADR_FLAGS    = 8'h01;
  localparam bus_adr_t ADR_REG_BASE = 8'h40;  // 0x40..0x7f, reg n in bits 5:0

endpackage

/* hdl/host_port.sv */
/*
  host port
  Wishbone classic slave for the integer slice. Decodes the address
  map, writes registers and flags, issues instructions and returns
  registered read data with a single cycle ack.
*/
`timescale 1ns/1ps

module host_port (
  input  logic               clk,
  input  logic               rst,
  input  logic               wb_cyc,
  input  logic               wb_stb,
  input  logic               wb_we,
  input  exec_pkg::bus_adr_t wb_adr,
  input  exec_pkg::data_t    wb_dat_w,
  output exec_pkg::data_t    wb_dat_r,
  output logic               wb_ack,
  output logic               issue,
  output exec_pkg::insn_t    issue_insn,
  output logic               host_we,
  output exec_pkg::reg_idx_t host_widx,
  output exec_pkg::data_t    host_wdata,
  output logic               host_flags_we,
  output exec_pkg::flags_t   host_flags,
  output exec_pkg::reg_idx_t host_ridx,
  input  exec_pkg::data_t    host_rdata,
  input  exec_pkg::flags_t   flags
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_EXEC,
    ST_ACK
  } state_t;

  state_t          state;
  logic            sample;
  logic            adr_reg;
  logic            adr_flags;
  logic            adr_issue;
  exec_pkg::data_t rd_mux;

  assign adr_reg   = wb_adr[7:6] == exec_pkg::ADR_REG_BASE[7:6];
  assign adr_flags = wb_adr == exec_pkg::ADR_FLAGS;
  assign adr_issue = wb_adr == exec_pkg::ADR_ISSUE;

  // request taken only from idle, so a held stb is not seen twice
  assign sample = wb_cyc & wb_stb & (state == ST_IDLE);

  assign host_we       = sample & wb_we & adr_reg;
  assign host_widx     = wb_adr[5:0];
  assign host_wdata    = wb_dat_w;
  assign host_flags_we = sample & wb_we & adr_flags;
  assign host_flags    = wb_dat_w[3:0];
  assign host_ridx     = wb_adr[5:0];

  assign issue      = sample & wb_we & adr_issue;
  assign issue_insn = wb_dat_w[31:0];

  always_comb begin
    rd_mux = '0;  // unmapped reads as zero
    if (adr_reg)
      rd_mux = host_rdata;
    else if (adr_flags)
      rd_mux = {60'd0, flags};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: if (sample) state <= issue ? ST_EXEC : ST_ACK;
        ST_EXEC: state <= ST_ACK;  // writeback edge
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (sample && !wb_we)
      wb_dat_r <= rd_mux;
  end

  assign wb_ack = state == ST_ACK;

endmodule

/* hdl/insn_decode.sv */
/*
  instruction decoder
  captures an issued instruction word and registers its opcode,
  condition, register indexes and sign extended immediate
*/
`timescale 1ns/1ps

module insn_decode (
  input  logic               clk,
  input  logic               rst,
  input  logic               issue,
  input  exec_pkg::insn_t    issue_insn,
  output logic               op_valid,
  output exec_pkg::alu_op_t  op,
  output exec_pkg::cond_t    cond,
  output exec_pkg::reg_idx_t rd,
  output exec_pkg::reg_idx_t ra,
  output exec_pkg::reg_idx_t rb,
  output exec_pkg::data_t    imm
);

  localparam int IMM_W = exec_pkg::INSN_IMM_W;

  exec_pkg::data_t imm_sx;

  assign imm_sx = {{(64 - IMM_W){issue_insn[IMM_W-1]}}, issue_insn[IMM_W-1:0]};

  // one cycle strobe, bus keeps issues apart
  always_ff @(posedge clk) begin
    if (rst)
      op_valid <= 1'b0;
    else
      op_valid <= issue;
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      op   <= issue_insn[exec_pkg::INSN_OP_LSB +: 4];
      cond <= issue_insn[exec_pkg::INSN_COND_LSB +: 4];
      rd   <= issue_insn[exec_pkg::INSN_RD_LSB +: 6];
      ra   <= issue_insn[exec_pkg::INSN_RA_LSB +: 6];
      rb   <= issue_insn[exec_pkg::INSN_RB_LSB +: 6];  // overlaps imm
      imm  <= imm_sx;
    end
  end

endmodule

/* hdl/int_alu.sv */
/*
  integer ALU
  operand select, add / sub, logic and shift results, carry, sign,
  overflow and zero flags, and the register and flags write enables
*/
`timescale 1ns/1ps

module int_alu (
  input  logic               op_valid,
  input  exec_pkg::alu_op_t  op,
  input  exec_pkg::reg_idx_t rd,
  input  exec_pkg::data_t    imm,
  input  exec_pkg::data_t    ra_data,
  input  exec_pkg::data_t    rb_data,
  input  exec_pkg::flags_t   flags,
  input  logic               cond_true,
  output logic               alu_we,
  output exec_pkg::reg_idx_t alu_rd,
  output exec_pkg::data_t    alu_wdata,
  output logic               flags_we,
  output exec_pkg::flags_t   new_flags
);

  logic            sub;
  logic            arith;
  logic            writes;
  logic            ovf;
  logic [64:0]     sum;
  logic [5:0]      shamt;
  exec_pkg::data_t opb;
  exec_pkg::data_t res;

  assign sub   = op == exec_pkg::OP_SUB;
  assign arith = (op == exec_pkg::OP_ADD) || sub || (op == exec_pkg::OP_ADDI);

  // reserved opcodes 10..15 write nothing
  assign writes = op <= exec_pkg::OP_MOVI;

  // one adder for add, sub and addi, sub as a + ~b + 1
  assign opb = (op == exec_pkg::OP_ADDI) ? imm : (sub ? ~rb_data : rb_data);
  assign sum = {1'b0, ra_data} + {1'b0, opb} + {64'd0, sub};
  assign ovf = (ra_data[63] == opb[63]) && (sum[63] != ra_data[63]);

  assign shamt = rb_data[5:0];

  always_comb begin
    res = '0;
    case (op)
      exec_pkg::OP_ADD,
      exec_pkg::OP_SUB,
      exec_pkg::OP_ADDI: res = sum[63:0];
      exec_pkg::OP_AND:  res = ra_data & rb_data;
      exec_pkg::OP_XOR:  res = ra_data ^ rb_data;
      exec_pkg::OP_OR:   res = ra_data | rb_data;
      exec_pkg::OP_SHL:  res = ra_data << shamt;
      exec_pkg::OP_SHR:  res = ra_data >> shamt;
      exec_pkg::OP_SAR:  res = $signed(ra_data) >>> shamt;
      exec_pkg::OP_MOVI: res = imm;
      default:           res = '0;
    endcase
  end

  always_comb begin
    new_flags = flags;  // held for reserved ops
    if (writes) begin
      new_flags[exec_pkg::FL_C] = arith & sum[64];
      new_flags[exec_pkg::FL_S] = res[63];
      new_flags[exec_pkg::FL_V] = arith & ovf;  // cleared for logic and shifts
      new_flags[exec_pkg::FL_Z] = res == '0;
    end
  end

  assign alu_wdata = res;
  assign alu_rd    = rd;

  assign alu_we   = op_valid & writes & cond_true;
  assign flags_we = op_valid & writes & cond_true;

endmodule

/* hdl/reg_file.sv */
/*
  register file
  64 x 64 bit general registers with two operand read ports, a host
  read port and a merged ALU / host write port, plus the flags register
*/
`timescale 1ns/1ps

module reg_file (
  input  logic               clk,
  input  logic               rst,
  input  exec_pkg::reg_idx_t ra,
  input  exec_pkg::reg_idx_t rb,
  output exec_pkg::data_t    ra_data,
  output exec_pkg::data_t    rb_data,
  input  exec_pkg::reg_idx_t host_ridx,
  output exec_pkg::data_t    host_rdata,
  input  logic               alu_we,
  input  exec_pkg::reg_idx_t rd,
  input  exec_pkg::data_t    alu_wdata,
  input  logic               flags_we,
  input  exec_pkg::flags_t   new_flags,
  input  logic               host_we,
  input  exec_pkg::reg_idx_t host_widx,
  input  exec_pkg::data_t    host_wdata,
  input  logic               host_flags_we,
  input  exec_pkg::flags_t   host_flags,
  output exec_pkg::flags_t   flags
);

  exec_pkg::data_t regs [64];

  // alu and host writes never meet, bus is serialized
  always_ff @(posedge clk) begin
    if (alu_we)
      regs[rd] <= alu_wdata;
    else if (host_we)
      regs[host_widx] <= host_wdata;
  end

  always_ff @(posedge clk) begin
    if (rst)
      flags <= '0;
    else if (flags_we)
      flags <= new_flags;
    else if (host_flags_we)
      flags <= host_flags;
  end

  assign ra_data    = regs[ra];
  assign rb_data    = regs[rb];
  assign host_rdata = regs[host_ridx];

endmodule

/* project.f */
+incdir+include
hdl/exec_pkg.sv
hdl/host_port.sv
hdl/insn_decode.sv
hdl/reg_file.sv
hdl/cond_eval.sv
hdl/int_alu.sv
hdl/exec_core.sv
testbench/exec_core_properties.sv
testbench/tb_exec_core.sv

/* testbench/exec_core_properties.sv */
/*
  bus checks for the host port
  ack only inside a cycle, single cycle ack, ack low out of reset,
  issue acked two edges after it is sampled
*/
`timescale 1ns/1ps

module exec_core_properties (
  input logic clk,
  input logic rst,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic issue
);

  int fail_count = 0;  // read by the testbench at the end

  a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
    wb_ack |-> wb_cyc && wb_stb)
    else begin
      $error("ack outside of an active bus cycle");
      fail_count++;
    end

  a_ack_single: assert property (@(posedge clk) disable iff (rst)
    wb_ack |=> !wb_ack)
    else begin
      $error("ack high on two consecutive cycles");
      fail_count++;
    end

  a_ack_reset: assert property (@(posedge clk) rst |=> !wb_ack)
    else begin
      $error("ack high after reset");
      fail_count++;
    end

  // exec state sits between sampling and ack
  a_issue_ack: assert property (@(posedge clk) disable iff (rst)
    issue |=> !wb_ack ##1 wb_ack)
    else begin
      $error("issue not acked two edges after sampling");
      fail_count++;
    end

endmodule

bind host_port exec_core_properties u_props (
  .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
  .wb_ack(wb_ack), .issue(issue)
);

/* include/exec_ref.svh */
/*
  reference model functions for the execution slice testbench
  condition table, ALU result and new flags
*/
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

function automatic bit ref_writes(exec_pkg::alu_op_t op);
  return op <= exec_pkg::OP_MOVI;
endfunction

function automatic bit ref_cond(exec_pkg::cond_t cc, exec_pkg::flags_t fl);
  bit c, s, v, z, base;
  c = fl[3];
  s = fl[2];
  v = fl[1];
  z = fl[0];
  case (cc[3:1])  // odd codes are the inverse of the even one below
    3'd0: base = z;
    3'd1: base = c;
    3'd2: base = s;
    3'd3: base = v;
    3'd4: base = c & ~z;
    3'd5: base = s ^ v;
    3'd6: base = ~z & (s == v);
    default: base = 1'b1;
  endcase
  return cc[0] ? ~base : base;
endfunction

function automatic exec_pkg::data_t ref_result(exec_pkg::alu_op_t op,
    exec_pkg::data_t a, exec_pkg::data_t b, exec_pkg::data_t imm);
  case (op)
    exec_pkg::OP_ADD:  return a + b;
    exec_pkg::OP_SUB:  return a - b;
    exec_pkg::OP_AND:  return a & b;
    exec_pkg::OP_XOR:  return a ^ b;
    exec_pkg::OP_OR:   return a | b;
    exec_pkg::OP_SHL:  return a << b[5:0];
    exec_pkg::OP_SHR:  return a >> b[5:0];
    exec_pkg::OP_SAR:  return $signed(a) >>> b[5:0];
    exec_pkg::OP_ADDI: return a + imm;
    exec_pkg::OP_MOVI: return imm;
    default:           return '0;
  endcase
endfunction

function automatic exec_pkg::flags_t ref_flags(exec_pkg::alu_op_t op,
    exec_pkg::data_t a, exec_pkg::data_t b, exec_pkg::data_t imm,
    exec_pkg::flags_t old);
  exec_pkg::data_t r;
  exec_pkg::data_t y;
  logic [64:0]     wide;
  exec_pkg::flags_t f;
  if (!ref_writes(op))
    return old;
  r = ref_result(op, a, b, imm);
  f = {1'b0, r[63], 1'b0, r == '0};
  if (op == exec_pkg::OP_ADD || op == exec_pkg::OP_ADDI || op == exec_pkg::OP_SUB) begin
    y    = (op == exec_pkg::OP_ADDI) ? imm : b;
    wide = (op == exec_pkg::OP_SUB) ? {1'b0, a} + {1'b0, ~y} + 65'd1 : {1'b0, a} + {1'b0, y};
    f[3] = wide[64];
    if (op == exec_pkg::OP_SUB)
      f[1] = (a[63] != y[63]) && (r[63] != a[63]);
    else
      f[1] = (a[63] == y[63]) && (r[63] != a[63]);
  end
  return f;
endfunction

`endif

/* testbench/tb_exec_core.sv */
/*
  testbench for the integer execution slice
  drives the Wishbone port with register, flags and issue accesses,
  tracks a shadow register file and compares every read back
*/
`timescale 1ns/1ps

module tb_exec_core;

  localparam int CLK_PERIOD = 20;
  localparam int N_ARITH    = 40;
  localparam int N_LOGIC    = 40;
  localparam int N_COND     = 60;
  localparam int N_OPS      = 128 + 5 * N_ARITH + 5 * N_LOGIC + 4 * N_COND + 71;

  logic               clk;
  logic               rst;
  logic               wb_cyc;
  logic               wb_stb;
  logic               wb_we;
  exec_pkg::bus_adr_t wb_adr;
  exec_pkg::data_t    wb_dat_w;
  exec_pkg::data_t    wb_dat_r;
  logic               wb_ack;

  exec_pkg::data_t    shadow [64];
  exec_pkg::flags_t   sh_flags;
  exec_pkg::data_t    exp_q [$];
  exec_pkg::data_t    act_q [$];
  string              name_q [$];
  int                 err_mis;
  int                 err_other;

  `include "exec_ref.svh"

  exec_core UUT (
    .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic exec_pkg::data_t rand64();
    return {$urandom, $urandom};
  endfunction

  // one classic cycle with ack watched at falling edges
  task automatic bus_xfer(input bit we, input exec_pkg::bus_adr_t adr,
      input exec_pkg::data_t wdat, output exec_pkg::data_t rdat);
    int waits;
    int want;
    want  = (we && adr == exec_pkg::ADR_ISSUE) ? 3 : 2;
    waits = 0;
    @(posedge clk);
    #2;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    do begin
      @(negedge clk);
      waits++;
    end while (!wb_ack && waits < 10);
    rdat = wb_dat_r;
    if (!wb_ack) begin
      err_other++;
      $display("%0t: no ack for access to address %h", $time, adr);
    end else if (waits != want) begin
      err_other++;
      $display("%0t: ack for address %h came %0d cycles after request, wanted %0d",
               $time, adr, waits, want);
    end
    @(posedge clk);
    #2;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(negedge clk);
    if (wb_ack) begin
      err_other++;
      $display("%0t: ack held longer than one cycle", $time);
    end
  endtask

  task automatic write_reg(input exec_pkg::reg_idx_t idx, input exec_pkg::data_t val);
    exec_pkg::data_t unused;
    bus_xfer(1'b1, exec_pkg::ADR_REG_BASE + idx, val, unused);
    shadow[idx] = val;
  endtask

  task automatic write_flags(input exec_pkg::flags_t f);
    exec_pkg::data_t unused;
    bus_xfer(1'b1, exec_pkg::ADR_FLAGS, {60'd0, f}, unused);
    sh_flags = f;
  endtask

  task automatic check_read(input exec_pkg::bus_adr_t adr, input exec_pkg::data_t exp,
      input string name);
    exec_pkg::data_t got;
    bus_xfer(1'b0, adr, '0, got);
    exp_q.push_back(exp);
    act_q.push_back(got);
    name_q.push_back(name);
  endtask

  task automatic check_reg(input exec_pkg::reg_idx_t idx);
    check_read(exec_pkg::ADR_REG_BASE + idx, shadow[idx], $sformatf("wb_dat_r (r%0d)", idx));
  endtask

  task automatic check_flags();
    check_read(exec_pkg::ADR_FLAGS, {60'd0, sh_flags}, "wb_dat_r (flags)");
  endtask

  // updates the shadow state, issues, then reads rd and flags back
  task automatic run_op(input exec_pkg::alu_op_t op, input exec_pkg::cond_t cc,
      input exec_pkg::reg_idx_t rd, input exec_pkg::reg_idx_t ra, input logic [11:0] low);
    exec_pkg::data_t a;
    exec_pkg::data_t b;
    exec_pkg::data_t imm;
    exec_pkg::data_t unused;
    a   = shadow[ra];
    b   = shadow[low[11:6]];
    imm = {{52{low[11]}}, low};
    if (ref_writes(op) && ref_cond(cc, sh_flags)) begin
      shadow[rd] = ref_result(op, a, b, imm);
      sh_flags   = ref_flags(op, a, b, imm, sh_flags);
    end
    bus_xfer(1'b1, exec_pkg::ADR_ISSUE, {32'd0, op, cc, rd, ra, low}, unused);
    check_reg(rd);
    check_flags();
  endtask

  task automatic random_op(input exec_pkg::alu_op_t op, input exec_pkg::cond_t cc,
      input bit load, input exec_pkg::data_t bval);
    exec_pkg::reg_idx_t rd;
    exec_pkg::reg_idx_t ra;
    exec_pkg::reg_idx_t rb;
    logic [11:0]        low;
    rd = 6'($urandom);
    ra = 6'($urandom);
    rb = 6'($urandom);
    if (load) begin
      write_reg(ra, rand64());
      write_reg(rb, bval);
    end
    low = {rb, 6'($urandom)};
    if (op == exec_pkg::OP_ADDI || op == exec_pkg::OP_MOVI)
      low = 12'($urandom);  // immediate shares the rb field
    run_op(op, cc, rd, ra, low);
  endtask

  initial begin : compare
    exec_pkg::data_t e;
    exec_pkg::data_t a;
    string           n;
    forever begin
      wait (act_q.size() != 0);
      e = exp_q.pop_front();
      a = act_q.pop_front();
      n = name_q.pop_front();
      if (a !== e) begin
        err_mis++;
        $display("MISMATCH %0t %s expected %h actual %h", $time, n, e, a);
      end
    end
  end

  initial begin : watchdog
    #(N_OPS * 10 * CLK_PERIOD + 100 * CLK_PERIOD);
    $display("watchdog expired before all bus operations completed");
    $display("Errors found");
    $finish;
  end

  initial begin : stimulus
    exec_pkg::data_t bval;
    exec_pkg::data_t unused;
    int              err_asrt;
    void'($urandom(32'h36f3));
    clk = 1'b0;
    rst = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    err_mis = 0;
    err_other = 0;
    sh_flags = '0;
    repeat (5) @(posedge clk);
    #2 rst = 1'b0;

    for (int i = 0; i < 64; i++)
      write_reg(6'(i), rand64());
    for (int i = 0; i < 64; i++)
      check_reg(6'(i));

    for (int n = 0; n < N_ARITH; n++) begin
      case ($urandom_range(0, 2))
        0: random_op(exec_pkg::OP_ADD, exec_pkg::CC_AL, 1'b1, rand64());
        1: random_op(exec_pkg::OP_SUB, exec_pkg::CC_AL, 1'b1, rand64());
        default: random_op(exec_pkg::OP_ADDI, exec_pkg::CC_AL, 1'b1, rand64());
      endcase
    end

    // logic, shifts and movi with shift amounts 0 and 63 among them
    for (int n = 0; n < N_LOGIC; n++) begin
      bval = rand64();
      if (n % 3 == 0)
        bval[5:0] = 6'd0;
      else if (n % 3 == 1)
        bval[5:0] = 6'd63;
      random_op(4'(exec_pkg::OP_AND + n % 8), exec_pkg::CC_AL, 1'b1, bval);
    end

    for (int n = 0; n < N_COND; n++) begin
      write_flags(4'($urandom));
      random_op(4'($urandom), 4'($urandom), 1'b0, '0);
    end

    check_read(8'h02, '0, "wb_dat_r (adr 02)");
    check_read(8'h3f, '0, "wb_dat_r (adr 3f)");
    check_read(8'h80, '0, "wb_dat_r (adr 80)");
    check_read(8'hff, '0, "wb_dat_r (adr ff)");
    bus_xfer(1'b1, 8'h25, rand64(), unused);
    bus_xfer(1'b1, 8'hc3, rand64(), unused);
    for (int i = 0; i < 64; i++)
      check_reg(6'(i));
    check_flags();

    wait (act_q.size() == 0);
    err_asrt = UUT.u_host_port.u_props.fail_count;
    $display("checks done: %0d mismatches, %0d other errors, %0d assertion failures",
             err_mis, err_other, err_asrt);
    if (err_mis == 0 && err_other == 0 && err_asrt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
